// ==== lpif_settings.svh ====
`ifndef LPIF_SETTINGS_SVH
`define LPIF_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Word widths
////////////////////////////////////////////////////////////////////////////

// One link-layer flit with all fields packed
`define LPIF_FLIT_W 154

// Raw PHY word per clock and direction
`define LPIF_PHY_W 160

////////////////////////////////////////////////////////////////////////////
// User bits above the flit
////////////////////////////////////////////////////////////////////////////

// Strobe sits right above the flit
`define LPIF_STB_BIT 154

// Low marker bit, marker spans 155 and 156
// Bits 157 to 159 are reserved and sent as zero
`define LPIF_MRK_LO 155

// Delay programming and beat counter sizes
`define LPIF_DELAY_W 16
`define LPIF_BEAT_CNT_W 16

`endif

// ==== lpif_pkg.sv ====
`include "lpif_settings.svh"

package lpif_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Link-layer types
  ////////////////////////////////////////////////////////////////////////////

  // Flit state codes, LPIF encoding
  typedef enum logic [7:0] {
    LPIF_ST_RESET     = 8'h00,
    LPIF_ST_ACTIVE    = 8'h01,
    LPIF_ST_LINKERROR = 8'h0a,
    LPIF_ST_RETRAIN   = 8'h0b
  } lpif_state_e;

  // Flit as seen by the link layer, MSB first
  typedef struct packed {
    logic [7:0]   state;
    logic [3:0]   protid;
    logic [127:0] data;
    logic [1:0]   dvalid;
    logic [7:0]   crc;
    logic [1:0]   crc_valid;
    logic [1:0]   valid;
  } lpif_flit_t;

  // Debug word, fixed at 32 bits
  typedef struct packed {
    logic [`LPIF_BEAT_CNT_W-1:0]     beat_count;
    logic                            tx_online;
    logic                            rx_online;
    logic                            strobe_live;
    logic [28-`LPIF_BEAT_CNT_W:0]    reserved;
  } lpif_debug_t;

endpackage

// ==== phy_pkg.sv ====
`include "lpif_settings.svh"

package phy_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // PHY-side types
  ////////////////////////////////////////////////////////////////////////////

  // One raw PHY word per direction
  // Flit in the low bits, user bits on top
  typedef struct packed {
    // Top bits, always zero
    logic [`LPIF_PHY_W-`LPIF_MRK_LO-3:0] reserved;
    // Alignment marker
    logic [1:0]                          marker;
    // Strobe user bit
    logic                                strobe;
    // Flit payload
    logic [`LPIF_FLIT_W-1:0]             flit;
  } phy_word_t;

  // Online sequencer states, one machine per direction
  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_WAIT,
    SYNC_ONLINE
  } sync_state_e;

endpackage

// ==== lpif_auto_sync.sv ====
`include "lpif_settings.svh"

module lpif_auto_sync (
  input  logic                     clk_wr,
  input  logic                     rst,
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  logic                     m_gen2_mode,
  input  logic [1:0]               tx_mrk_userbit,
  input  logic                     tx_stb_userbit,
  input  logic [`LPIF_DELAY_W-1:0] delay_x_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_y_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_z_value,
  output logic                     tx_online_delay,
  output logic                     rx_online_delay,
  output logic [1:0]               tx_auto_mrk_userbit,
  output logic                     tx_auto_stb_userbit,
  output logic                     strobe_live
);

  import phy_pkg::*;

  // Lane 0 is transmit, lane 1 is receive
  logic [1:0]                    raw_online;
  logic [1:0][`LPIF_DELAY_W-1:0] lane_delay;
  logic [1:0]                    online_q;
  logic [1:0]                    online_d;

  // Strobe hold-off after transmit goes online
  logic [`LPIF_DELAY_W-1:0]      z_cnt_q;
  logic [`LPIF_DELAY_W-1:0]      z_cnt_d;
  logic                          live_d;

  assign raw_online = {rx_online, tx_online};
  assign lane_delay = {delay_x_value, delay_y_value};

  ////////////////////////////////////////////////////////////////////////////
  // Online sequencers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : g_lane
    sync_state_e              st_q;
    sync_state_e              st_d;
    logic [`LPIF_DELAY_W-1:0] cnt_q;
    logic [`LPIF_DELAY_W-1:0] cnt_d;

    always_comb begin
      st_d  = st_q;
      cnt_d = cnt_q;
      case (st_q)
        SYNC_IDLE: begin
          // Load delay on first sampled high
          if (raw_online[i]) begin
            st_d  = SYNC_WAIT;
            cnt_d = lane_delay[i];
          end
        end
        SYNC_WAIT: begin
          if (!raw_online[i]) begin
            st_d = SYNC_IDLE;
          end else if (cnt_q == '0) begin
            st_d = SYNC_ONLINE;
          end else begin
            cnt_d = cnt_q - `LPIF_DELAY_W'(1);
          end
        end
        SYNC_ONLINE: begin
          // Drop as soon as raw online is seen low
          if (!raw_online[i]) begin
            st_d = SYNC_IDLE;
          end
        end
        default: st_d = SYNC_IDLE;
      endcase
    end

    always_ff @(posedge clk_wr) begin
      if (rst) begin
        st_q  <= SYNC_IDLE;
        cnt_q <= '0;
      end else begin
        st_q  <= st_d;
        cnt_q <= cnt_d;
      end
    end

    assign online_q[i] = (st_q == SYNC_ONLINE);
    assign online_d[i] = (st_d == SYNC_ONLINE);
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

  ////////////////////////////////////////////////////////////////////////////
  // Marker and strobe user bits
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    z_cnt_d = z_cnt_q;
    live_d  = strobe_live;
    if (!online_d[0]) begin
      z_cnt_d = '0;
      live_d  = 1'b0;
    end else if (!online_q[0]) begin
      // Entering online, start hold-off
      z_cnt_d = delay_z_value;
      live_d  = (delay_z_value == '0);
    end else if (z_cnt_q != '0) begin
      z_cnt_d = z_cnt_q - `LPIF_DELAY_W'(1);
      live_d  = (z_cnt_q == `LPIF_DELAY_W'(1));
    end
  end

  // Registered with online so both change on the same edge
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      z_cnt_q             <= '0;
      strobe_live         <= 1'b0;
      tx_auto_stb_userbit <= 1'b0;
      tx_auto_mrk_userbit <= 2'b00;
    end else begin
      z_cnt_q             <= z_cnt_d;
      strobe_live         <= live_d;
      tx_auto_stb_userbit <= live_d & tx_stb_userbit;
      // Gen1 uses only the low marker bit
      tx_auto_mrk_userbit <= online_d[0] ?
                             {tx_mrk_userbit[1] & m_gen2_mode, tx_mrk_userbit[0]} : 2'b00;
    end
  end

endmodule

// ==== lpif_phy_concat.sv ====
module lpif_phy_concat (
  input  logic                 clk_wr,
  input  logic                 rst,
  input  lpif_pkg::lpif_flit_t ustrm,
  input  phy_pkg::phy_word_t   rx_phy0,
  input  logic                 tx_online_delay,
  input  logic                 rx_online_delay,
  input  logic [1:0]           tx_auto_mrk_userbit,
  input  logic                 tx_auto_stb_userbit,
  output phy_pkg::phy_word_t   tx_phy0,
  output lpif_pkg::lpif_flit_t dstrm,
  output logic                 rx_beat
);

  import lpif_pkg::*;
  import phy_pkg::*;

  phy_word_t  tx_word;
  lpif_flit_t rx_flit;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit packer
  ////////////////////////////////////////////////////////////////////////////

  // Flit in the low bits, user bits above
  always_comb begin
    tx_word.reserved = '0;
    tx_word.marker   = tx_auto_mrk_userbit;
    tx_word.strobe   = tx_auto_stb_userbit;
    tx_word.flit     = ustrm;
  end

  // One clock of latency
  // Word forced to zero while transmit is offline
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online_delay) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_word;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive unpacker
  ////////////////////////////////////////////////////////////////////////////

  // User bits above the flit are dropped here
  assign rx_flit = lpif_flit_t'(rx_phy0.flit);

  // No ready downstream
  // Every flit taken while online is delivered
  always_ff @(posedge clk_wr) begin
    if (rst || !rx_online_delay) begin
      dstrm <= '0;
    end else begin
      dstrm <= rx_flit;
    end
  end

  // One beat per delivered flit with any valid
  assign rx_beat = |dstrm.valid;

endmodule

// ==== lpif_link_status.sv ====
`include "lpif_settings.svh"

module lpif_link_status (
  input  logic                  clk_wr,
  input  logic                  rst,
  input  logic                  rx_beat,
  input  logic                  tx_online_delay,
  input  logic                  rx_online_delay,
  input  logic                  strobe_live,
  output lpif_pkg::lpif_debug_t rx_downstream_debug_status,
  output lpif_pkg::lpif_debug_t tx_upstream_debug_status
);

  import lpif_pkg::*;

  logic [`LPIF_BEAT_CNT_W-1:0] beat_cnt_q;
  logic                        tx_on_q;
  logic                        rx_on_q;
  logic                        live_q;
  lpif_debug_t                 status_w;

  // Beat counter sticks at all ones
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      beat_cnt_q <= '0;
      tx_on_q    <= 1'b0;
      rx_on_q    <= 1'b0;
      live_q     <= 1'b0;
    end else begin
      if (rx_beat && (beat_cnt_q != '1)) begin
        beat_cnt_q <= beat_cnt_q + `LPIF_BEAT_CNT_W'(1);
      end
      tx_on_q <= tx_online_delay;
      rx_on_q <= rx_online_delay;
      live_q  <= strobe_live;
    end
  end

  // Both words from the same registered flags
  always_comb begin
    status_w.beat_count  = beat_cnt_q;
    status_w.tx_online   = tx_on_q;
    status_w.rx_online   = rx_on_q;
    status_w.strobe_live = live_q;
    status_w.reserved    = '0;
  end

  assign rx_downstream_debug_status = status_w;

  // Nothing to count on transmit
  always_comb begin
    tx_upstream_debug_status            = status_w;
    tx_upstream_debug_status.beat_count = '0;
  end

endmodule

// ==== lpif_slave_top.sv ====
`include "lpif_settings.svh"

module lpif_slave_top (
  input  logic                     clk_wr,
  input  logic                     rst,
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  logic                     m_gen2_mode,
  input  logic [1:0]               tx_mrk_userbit,
  input  logic                     tx_stb_userbit,
  input  logic [`LPIF_DELAY_W-1:0] delay_x_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_y_value,
  input  logic [`LPIF_DELAY_W-1:0] delay_z_value,
  input  lpif_pkg::lpif_flit_t     ustrm,
  output lpif_pkg::lpif_flit_t     dstrm,
  output phy_pkg::phy_word_t       tx_phy0,
  input  phy_pkg::phy_word_t       rx_phy0,
  output lpif_pkg::lpif_debug_t    rx_downstream_debug_status,
  output lpif_pkg::lpif_debug_t    tx_upstream_debug_status
);

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////////////////////

  logic       tx_online_delay;
  logic       rx_online_delay;
  logic [1:0] tx_auto_mrk_userbit;
  logic       tx_auto_stb_userbit;
  logic       strobe_live;
  logic       rx_beat;

  // Online sequencing and user bits
  lpif_auto_sync u_auto_sync (
    .clk_wr, .rst, .tx_online, .rx_online, .m_gen2_mode,
    .tx_mrk_userbit, .tx_stb_userbit,
    .delay_x_value, .delay_y_value, .delay_z_value,
    .tx_online_delay, .rx_online_delay,
    .tx_auto_mrk_userbit, .tx_auto_stb_userbit, .strobe_live
  );

  // PHY word packing both ways
  lpif_phy_concat u_phy_concat (
    .clk_wr, .rst, .ustrm, .rx_phy0,
    .tx_online_delay, .rx_online_delay,
    .tx_auto_mrk_userbit, .tx_auto_stb_userbit,
    .tx_phy0, .dstrm, .rx_beat
  );

  // Debug words
  lpif_link_status u_link_status (
    .clk_wr, .rst, .rx_beat,
    .tx_online_delay, .rx_online_delay, .strobe_live,
    .rx_downstream_debug_status, .tx_upstream_debug_status
  );

endmodule

// ==== lpif_slave_asserts.sv ====
module lpif_slave_asserts (
  input logic                  clk_wr,
  input logic                  rst,
  input logic                  m_gen2_mode,
  input logic                  tx_online_delay,
  input logic                  rx_online_delay,
  input logic [1:0]            tx_auto_mrk_userbit,
  input logic                  tx_auto_stb_userbit,
  input phy_pkg::phy_word_t    tx_phy0,
  input lpif_pkg::lpif_flit_t  dstrm,
  input lpif_pkg::lpif_debug_t rx_downstream_debug_status,
  input lpif_pkg::lpif_debug_t tx_upstream_debug_status
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Transmit register loads zero on an edge that sees transmit offline
  a_tx_offline: assert property (@(posedge clk_wr) disable iff (rst)
    !tx_online_delay |=> (tx_phy0 == '0))
    else begin
      fail_count++;
      $error("tx_phy0 carried data while transmit was offline");
    end

  // Same on receive, no valid flit leaks out
  a_rx_offline: assert property (@(posedge clk_wr) disable iff (rst)
    !rx_online_delay |=> (dstrm.valid == 2'b00))
    else begin
      fail_count++;
      $error("dstrm.valid set while receive was offline");
    end

  // Gen1 marker uses the low bit only
  a_gen1_marker: assert property (@(posedge clk_wr) disable iff (rst)
    !m_gen2_mode |=> !tx_auto_mrk_userbit[1])
    else begin
      fail_count++;
      $error("marker high bit set in gen1 mode");
    end

  // Everything cleared one cycle after reset
  a_reset_zero: assert property (@(posedge clk_wr)
    rst |=> (tx_phy0 == '0 && dstrm == '0 && !tx_online_delay && !rx_online_delay &&
             tx_auto_mrk_userbit == 2'b00 && !tx_auto_stb_userbit &&
             rx_downstream_debug_status == '0 && tx_upstream_debug_status == '0))
    else begin
      fail_count++;
      $error("outputs not cleared after reset");
    end

endmodule

bind lpif_slave_top lpif_slave_asserts u_asserts (
  .clk_wr                     (clk_wr),
  .rst                        (rst),
  .m_gen2_mode                (m_gen2_mode),
  .tx_online_delay            (tx_online_delay),
  .rx_online_delay            (rx_online_delay),
  .tx_auto_mrk_userbit        (tx_auto_mrk_userbit),
  .tx_auto_stb_userbit        (tx_auto_stb_userbit),
  .tx_phy0                    (tx_phy0),
  .dstrm                      (dstrm),
  .rx_downstream_debug_status (rx_downstream_debug_status),
  .tx_upstream_debug_status   (tx_upstream_debug_status)
);

// ==== tb_lpif_slave_top.sv ====
`include "lpif_settings.svh"

module tb_lpif_slave_top;

  import lpif_pkg::*;
  import phy_pkg::*;

  localparam int CW = `LPIF_PHY_W;

  logic                     clk_wr;
  logic                     rst;
  logic                     tx_online;
  logic                     rx_online;
  logic                     m_gen2_mode;
  logic [1:0]               tx_mrk_userbit;
  logic                     tx_stb_userbit;
  logic [`LPIF_DELAY_W-1:0] delay_x_value;
  logic [`LPIF_DELAY_W-1:0] delay_y_value;
  logic [`LPIF_DELAY_W-1:0] delay_z_value;
  lpif_flit_t               ustrm;
  lpif_flit_t               dstrm;
  // PHY loopback from transmit straight into receive
  phy_word_t                phy_loop;
  lpif_debug_t              rx_status;
  lpif_debug_t              tx_status;

  integer seed;
  int     errors;
  int     checks;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////////////////////////////////////////

  // Consecutive high samples of raw online per direction
  // Index 0 is tx and index 1 is rx
  int          hi_cnt [2];
  // Clocks since transmit went online
  int          on_cnt;
  logic        m_tx_on;
  logic        m_rx_on;
  logic        m_live;
  logic        m_stb;
  logic [1:0]  m_mrk;
  phy_word_t   m_tx;
  lpif_flit_t  m_dstrm;
  lpif_debug_t m_status;

  lpif_slave_top DUT (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .m_gen2_mode                (m_gen2_mode),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value),
    .ustrm                      (ustrm),
    .dstrm                      (dstrm),
    .tx_phy0                    (phy_loop),
    .rx_phy0                    (phy_loop),
    .rx_downstream_debug_status (rx_status),
    .tx_upstream_debug_status   (tx_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever begin
      #10 clk_wr = ~clk_wr;
    end
  end

  task automatic check(input string name, input logic [CW-1:0] exp_val,
                       input logic [CW-1:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  // One clock of the model taken right at the rising edge
  task automatic update_model();
    logic        tx_on_n;
    logic        rx_on_n;
    logic        live_n;
    phy_word_t   tx_n;
    lpif_debug_t status_n;
    if (rst) begin
      hi_cnt[0] = 0;
      hi_cnt[1] = 0;
      on_cnt    = 0;
      m_tx_on   = 1'b0;
      m_rx_on   = 1'b0;
      m_live    = 1'b0;
      m_stb     = 1'b0;
      m_mrk     = 2'b00;
      m_tx      = '0;
      m_dstrm   = '0;
      m_status  = '0;
    end else begin
      // Packer uses the user bits held before this edge
      tx_n = '0;
      if (m_tx_on) begin
        tx_n.marker = m_mrk;
        tx_n.strobe = m_stb;
        tx_n.flit   = ustrm;
      end
      status_n             = m_status;
      status_n.tx_online   = m_tx_on;
      status_n.rx_online   = m_rx_on;
      status_n.strobe_live = m_live;
      if ((|m_dstrm.valid) && (m_status.beat_count != '1)) begin
        status_n.beat_count = m_status.beat_count + `LPIF_BEAT_CNT_W'(1);
      end
      // Online once D+2 high samples are in with the first one counted
      hi_cnt[0] = tx_online ? hi_cnt[0] + 1 : 0;
      hi_cnt[1] = rx_online ? hi_cnt[1] + 1 : 0;
      tx_on_n   = (hi_cnt[0] >= int'(delay_y_value) + 2);
      rx_on_n   = (hi_cnt[1] >= int'(delay_x_value) + 2);
      // Strobe held back Z clocks
      on_cnt    = tx_on_n ? on_cnt + 1 : 0;
      live_n    = tx_on_n && (on_cnt > int'(delay_z_value));
      m_stb     = live_n & tx_stb_userbit;
      m_mrk     = tx_on_n ? {tx_mrk_userbit[1] & m_gen2_mode, tx_mrk_userbit[0]} : 2'b00;
      m_dstrm   = m_rx_on ? lpif_flit_t'(m_tx.flit) : '0;
      m_live    = live_n;
      m_tx_on   = tx_on_n;
      m_rx_on   = rx_on_n;
      m_tx      = tx_n;
      m_status  = status_n;
    end
  endtask

  task automatic compare_outputs();
    lpif_debug_t exp_tx_status;
    exp_tx_status            = m_status;
    exp_tx_status.beat_count = '0;
    check("tx_phy0", CW'(m_tx), CW'(phy_loop));
    check("dstrm", CW'(m_dstrm), CW'(dstrm));
    check("rx debug status", CW'(m_status), CW'(rx_status));
    check("tx debug status", CW'(exp_tx_status), CW'(tx_status));
  endtask

  // Model at the edge and compare one unit later
  // Returns two units after the edge for driving
  task automatic step();
    @(posedge clk_wr);
    update_model();
    #1;
    compare_outputs();
    #1;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    lpif_flit_t  f;
    r = $random(seed);
    case (r[1:0])
      2'd0: f.state = LPIF_ST_RESET;
      2'd1: f.state = LPIF_ST_ACTIVE;
      2'd2: f.state = LPIF_ST_RETRAIN;
      default: f.state = LPIF_ST_LINKERROR;
    endcase
    f.protid          = r[5:2];
    f.dvalid          = r[7:6];
    f.crc             = r[15:8];
    f.crc_valid       = r[17:16];
    // Zero valid a quarter of the time
    f.valid           = r[19:18];
    tx_stb_userbit    = r[20];
    tx_mrk_userbit    = r[22:21];
    f.data[31:0]      = $random(seed);
    f.data[63:32]     = $random(seed);
    f.data[95:64]     = $random(seed);
    f.data[127:96]    = $random(seed);
    ustrm             = f;
  endtask

  // Traffic keeps running while waiting on the debug flags
  task automatic wait_status(input logic level, input int limit,
                             output int tx_n, output int rx_n);
    int n;
    tx_n = 0;
    rx_n = 0;
    n    = 0;
    while ((tx_n == 0 || rx_n == 0) && n < limit) begin
      step();
      n++;
      if (tx_n == 0 && rx_status.tx_online == level) begin
        tx_n = n;
      end
      if (rx_n == 0 && rx_status.rx_online == level) begin
        rx_n = n;
      end
      drive_random();
    end
    if (tx_n == 0 || rx_n == 0) begin
      errors++;
      $display("Timeout: debug online flags did not reach %0b within %0d clocks",
               level, limit);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          tx_edge;
    int          rx_edge;
    logic [31:0] r;
    seed           = 82;
    errors         = 0;
    checks         = 0;
    rst            = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    m_gen2_mode    = 1'b0;
    tx_mrk_userbit = 2'b00;
    tx_stb_userbit = 1'b0;
    delay_x_value  = '0;
    delay_y_value  = '0;
    delay_z_value  = '0;
    ustrm          = '0;
    repeat (8) step();
    rst = 1'b0;

    for (int p = 0; p < 6; p++) begin
      // Delays change only with both directions down
      r             = $random(seed);
      delay_x_value = `LPIF_DELAY_W'(r[2:0]);
      delay_y_value = `LPIF_DELAY_W'(r[5:3]);
      delay_z_value = `LPIF_DELAY_W'(r[8:6]);
      // Gen1 and gen2 take turns across passes
      m_gen2_mode   = p[0];
      // Offline traffic where nothing may pass
      repeat (4) begin
        drive_random();
        step();
      end
      drive_random();
      tx_online = 1'b1;
      rx_online = 1'b1;
      // Flag seen D+2 clocks after the first sampling edge
      wait_status(1'b1, 40, tx_edge, rx_edge);
      check("tx online rise", CW'(int'(delay_y_value) + 3), CW'(tx_edge));
      check("rx online rise", CW'(int'(delay_x_value) + 3), CW'(rx_edge));
      repeat (40) begin
        step();
        drive_random();
      end
      tx_online = 1'b0;
      rx_online = 1'b0;
      wait_status(1'b0, 10, tx_edge, rx_edge);
      check("tx online fall", CW'(2), CW'(tx_edge));
      check("rx online fall", CW'(2), CW'(rx_edge));
      repeat (3) step();
    end

    check("final beat count", CW'(m_status.beat_count), CW'(rx_status.beat_count));
    if (m_status.beat_count == '0) begin
      errors++;
      $display("No flit with a valid bit was delivered downstream");
    end
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, DUT.u_asserts.fail_count);
    if (errors == 0 && DUT.u_asserts.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== lpif_slave_top.f ====
+incdir+.
lpif_pkg.sv
phy_pkg.sv
lpif_auto_sync.sv
lpif_phy_concat.sv
lpif_link_status.sv
lpif_slave_top.sv
lpif_slave_asserts.sv
tb_lpif_slave_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_lpif_slave_top
FILELIST   = lpif_slave_top.f
OBJ_DIR    = obj_dir
PASS_MSG   = test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
